/* common/id_pkg.sv */
package id_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // which fields take part in a match
  localparam word_t MASK_OPCODE = 32'b0000000_00000_00000_000_00000_1111111;
  localparam word_t MASK_FUNC3  = 32'b0000000_00000_00000_111_00000_1111111;
  localparam word_t MASK_FUNC7  = 32'b1111111_00000_00000_111_00000_1111111;
  localparam word_t MASK_ALL    = 32'hffff_ffff;

  // rv32i
  localparam word_t PAT_LUI    = 32'b0000000_00000_00000_000_00000_0110111;
  localparam word_t PAT_AUIPC  = 32'b0000000_00000_00000_000_00000_0010111;
  localparam word_t PAT_JAL    = 32'b0000000_00000_00000_000_00000_1101111;
  localparam word_t PAT_JALR   = 32'b0000000_00000_00000_000_00000_1100111;
  localparam word_t PAT_BEQ    = 32'b0000000_00000_00000_000_00000_1100011;
  localparam word_t PAT_BNE    = 32'b0000000_00000_00000_001_00000_1100011;
  localparam word_t PAT_BLT    = 32'b0000000_00000_00000_100_00000_1100011;
  localparam word_t PAT_BGE    = 32'b0000000_00000_00000_101_00000_1100011;
  localparam word_t PAT_BLTU   = 32'b0000000_00000_00000_110_00000_1100011;
  localparam word_t PAT_BGEU   = 32'b0000000_00000_00000_111_00000_1100011;
  localparam word_t PAT_LB     = 32'b0000000_00000_00000_000_00000_0000011;
  localparam word_t PAT_LH     = 32'b0000000_00000_00000_001_00000_0000011;
  localparam word_t PAT_LW     = 32'b0000000_00000_00000_010_00000_0000011;
  localparam word_t PAT_LBU    = 32'b0000000_00000_00000_100_00000_0000011;
  localparam word_t PAT_LHU    = 32'b0000000_00000_00000_101_00000_0000011;
  localparam word_t PAT_SB     = 32'b0000000_00000_00000_000_00000_0100011;
  localparam word_t PAT_SH     = 32'b0000000_00000_00000_001_00000_0100011;
  localparam word_t PAT_SW     = 32'b0000000_00000_00000_010_00000_0100011;
  localparam word_t PAT_ADDI   = 32'b0000000_00000_00000_000_00000_0010011;
  localparam word_t PAT_SLTI   = 32'b0000000_00000_00000_010_00000_0010011;
  localparam word_t PAT_SLTIU  = 32'b0000000_00000_00000_011_00000_0010011;
  localparam word_t PAT_XORI   = 32'b0000000_00000_00000_100_00000_0010011;
  localparam word_t PAT_ORI    = 32'b0000000_00000_00000_110_00000_0010011;
  localparam word_t PAT_ANDI   = 32'b0000000_00000_00000_111_00000_0010011;
  localparam word_t PAT_SLLI   = 32'b0000000_00000_00000_001_00000_0010011;
  localparam word_t PAT_SRLI   = 32'b0000000_00000_00000_101_00000_0010011;
  localparam word_t PAT_SRAI   = 32'b0100000_00000_00000_101_00000_0010011;
  localparam word_t PAT_ADD    = 32'b0000000_00000_00000_000_00000_0110011;
  localparam word_t PAT_SUB    = 32'b0100000_00000_00000_000_00000_0110011;
  localparam word_t PAT_SLL    = 32'b0000000_00000_00000_001_00000_0110011;
  localparam word_t PAT_SLT    = 32'b0000000_00000_00000_010_00000_0110011;
  localparam word_t PAT_SLTU   = 32'b0000000_00000_00000_011_00000_0110011;
  localparam word_t PAT_XOR    = 32'b0000000_00000_00000_100_00000_0110011;
  localparam word_t PAT_SRL    = 32'b0000000_00000_00000_101_00000_0110011;
  localparam word_t PAT_SRA    = 32'b0100000_00000_00000_101_00000_0110011;
  localparam word_t PAT_OR     = 32'b0000000_00000_00000_110_00000_0110011;
  localparam word_t PAT_AND    = 32'b0000000_00000_00000_111_00000_0110011;
  localparam word_t PAT_ECALL  = 32'h0000_0073;
  localparam word_t PAT_EBREAK = 32'h0010_0073;
  localparam word_t PAT_MRET   = 32'h3020_0073;

  // rv32m
  localparam word_t PAT_MUL    = 32'b0000001_00000_00000_000_00000_0110011;
  localparam word_t PAT_MULH   = 32'b0000001_00000_00000_001_00000_0110011;
  localparam word_t PAT_MULHSU = 32'b0000001_00000_00000_010_00000_0110011;
  localparam word_t PAT_MULHU  = 32'b0000001_00000_00000_011_00000_0110011;
  localparam word_t PAT_DIV    = 32'b0000001_00000_00000_100_00000_0110011;
  localparam word_t PAT_DIVU   = 32'b0000001_00000_00000_101_00000_0110011;
  localparam word_t PAT_REM    = 32'b0000001_00000_00000_110_00000_0110011;
  localparam word_t PAT_REMU   = 32'b0000001_00000_00000_111_00000_0110011;

  // return address is the next sequential instruction
  localparam word_t CALL_RET_OFFSET = 32'd4;

  typedef enum logic [4:0] {
    ALU_NONE, ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
    ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
  } alu_op_e;

  typedef enum logic [3:0] {
    EXC_NONE, EXC_LUI, EXC_AUIPC, EXC_JAL, EXC_JALR, EXC_LOAD, EXC_STORE,
    EXC_BRANCH, EXC_OPIMM, EXC_OPREG, EXC_SYSTEM
  } exc_op_e;

  typedef enum logic [3:0] {
    MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_SB, MEM_SH, MEM_SW
  } mem_op_e;

  typedef enum logic [2:0] {
    IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_fmt_e;

  typedef struct packed {
    logic mret;
    logic ebreak;
    logic ecall_m;
    logic illegal;
  } trap_t;

  typedef struct packed {
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t rd_idx;
    alu_op_e  alu_op;
    exc_op_e  exc_op;
    mem_op_e  mem_op;
    imm_fmt_e imm_fmt;
    trap_t    trap;
    logic     is_call;
  } decode_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    inst;
    reg_idx_t rd_idx;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    alu_op_e  alu_op;
    exc_op_e  exc_op;
    mem_op_e  mem_op;
    trap_t    trap;
  } id_ex_t;

endpackage

/* hw/decode/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  id_pkg::word_t   inst_i,
  output id_pkg::decode_t dec_o
);

  function automatic logic hit(input id_pkg::word_t inst, input id_pkg::word_t mask,
                               input id_pkg::word_t pat);
    hit = (inst & mask) == pat;
  endfunction

  wire i_lui    = hit(inst_i, id_pkg::MASK_OPCODE, id_pkg::PAT_LUI);
  wire i_auipc  = hit(inst_i, id_pkg::MASK_OPCODE, id_pkg::PAT_AUIPC);
  wire i_jal    = hit(inst_i, id_pkg::MASK_OPCODE, id_pkg::PAT_JAL);
  wire i_jalr   = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_JALR);
  wire i_beq    = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_BEQ);
  wire i_bne    = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_BNE);
  wire i_blt    = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_BLT);
  wire i_bge    = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_BGE);
  wire i_bltu   = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_BLTU);
  wire i_bgeu   = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_BGEU);
  wire i_lb     = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_LB);
  wire i_lh     = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_LH);
  wire i_lw     = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_LW);
  wire i_lbu    = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_LBU);
  wire i_lhu    = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_LHU);
  wire i_sb     = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_SB);
  wire i_sh     = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_SH);
  wire i_sw     = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_SW);
  wire i_addi   = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_ADDI);
  wire i_slti   = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_SLTI);
  wire i_sltiu  = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_SLTIU);
  wire i_xori   = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_XORI);
  wire i_ori    = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_ORI);
  wire i_andi   = hit(inst_i, id_pkg::MASK_FUNC3, id_pkg::PAT_ANDI);
  // shift immediates also check the upper funct7 bits
  wire i_slli   = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_SLLI);
  wire i_srli   = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_SRLI);
  wire i_srai   = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_SRAI);
  wire i_add    = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_ADD);
  wire i_sub    = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_SUB);
  wire i_sll    = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_SLL);
  wire i_slt    = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_SLT);
  wire i_sltu   = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_SLTU);
  wire i_xor    = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_XOR);
  wire i_srl    = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_SRL);
  wire i_sra    = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_SRA);
  wire i_or     = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_OR);
  wire i_and    = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_AND);
  wire i_mul    = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_MUL);
  wire i_mulh   = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_MULH);
  wire i_mulhsu = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_MULHSU);
  wire i_mulhu  = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_MULHU);
  wire i_div    = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_DIV);
  wire i_divu   = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_DIVU);
  wire i_rem    = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_REM);
  wire i_remu   = hit(inst_i, id_pkg::MASK_FUNC7, id_pkg::PAT_REMU);
  wire i_ecall  = hit(inst_i, id_pkg::MASK_ALL, id_pkg::PAT_ECALL);
  wire i_ebreak = hit(inst_i, id_pkg::MASK_ALL, id_pkg::PAT_EBREAK);
  wire i_mret   = hit(inst_i, id_pkg::MASK_ALL, id_pkg::PAT_MRET);

  wire c_branch = i_beq | i_bne | i_blt | i_bge | i_bltu | i_bgeu;
  wire c_load   = i_lb | i_lh | i_lw | i_lbu | i_lhu;
  wire c_store  = i_sb | i_sh | i_sw;
  wire c_opimm  = i_addi | i_slti | i_sltiu | i_xori | i_ori | i_andi |
                  i_slli | i_srli | i_srai;
  wire c_muldiv = i_mul | i_mulh | i_mulhsu | i_mulhu | i_div | i_divu | i_rem | i_remu;
  wire c_opreg  = i_add | i_sub | i_sll | i_slt | i_sltu | i_xor | i_srl | i_sra |
                  i_or | i_and | c_muldiv;
  // csr opcodes have no pattern here and fall through to illegal
  wire c_system = i_ecall | i_ebreak | i_mret;

  // instruction formats
  wire f_r = c_opreg;
  wire f_i = c_load | c_opimm | i_jalr | c_system;
  wire f_s = c_store;
  wire f_b = c_branch;
  wire f_u = i_lui | i_auipc;
  wire f_j = i_jal;
  wire illegal = ~(f_r | f_i | f_s | f_b | f_u | f_j);

  always_comb begin
    dec_o = '0;
    dec_o.rs1_idx = (f_r | f_i | f_s | f_b) ? inst_i[19:15] : 5'd0;
    dec_o.rs2_idx = (f_r | f_s | f_b) ? inst_i[24:20] : 5'd0;
    dec_o.rd_idx  = (f_r | f_i | f_u | f_j) ? inst_i[11:7] : 5'd0;

    // address and link arithmetic all go through the adder
    if (i_add | i_addi | c_load | c_store | i_jal | i_jalr | i_auipc | i_lui)
      dec_o.alu_op = id_pkg::ALU_ADD;
    if (i_sub)           dec_o.alu_op = id_pkg::ALU_SUB;
    if (i_xor | i_xori)  dec_o.alu_op = id_pkg::ALU_XOR;
    if (i_or | i_ori)    dec_o.alu_op = id_pkg::ALU_OR;
    if (i_and | i_andi)  dec_o.alu_op = id_pkg::ALU_AND;
    if (i_sll | i_slli)  dec_o.alu_op = id_pkg::ALU_SLL;
    if (i_srl | i_srli)  dec_o.alu_op = id_pkg::ALU_SRL;
    if (i_sra | i_srai)  dec_o.alu_op = id_pkg::ALU_SRA;
    if (i_slt | i_slti)  dec_o.alu_op = id_pkg::ALU_SLT;
    if (i_sltu | i_sltiu) dec_o.alu_op = id_pkg::ALU_SLTU;
    if (i_beq)    dec_o.alu_op = id_pkg::ALU_BEQ;
    if (i_bne)    dec_o.alu_op = id_pkg::ALU_BNE;
    if (i_blt)    dec_o.alu_op = id_pkg::ALU_BLT;
    if (i_bge)    dec_o.alu_op = id_pkg::ALU_BGE;
    if (i_bltu)   dec_o.alu_op = id_pkg::ALU_BLTU;
    if (i_bgeu)   dec_o.alu_op = id_pkg::ALU_BGEU;
    if (i_mul)    dec_o.alu_op = id_pkg::ALU_MUL;
    if (i_mulh)   dec_o.alu_op = id_pkg::ALU_MULH;
    if (i_mulhsu) dec_o.alu_op = id_pkg::ALU_MULHSU;
    if (i_mulhu)  dec_o.alu_op = id_pkg::ALU_MULHU;
    if (i_div)    dec_o.alu_op = id_pkg::ALU_DIV;
    if (i_divu)   dec_o.alu_op = id_pkg::ALU_DIVU;
    if (i_rem)    dec_o.alu_op = id_pkg::ALU_REM;
    if (i_remu)   dec_o.alu_op = id_pkg::ALU_REMU;

    if (i_lui)    dec_o.exc_op = id_pkg::EXC_LUI;
    if (i_auipc)  dec_o.exc_op = id_pkg::EXC_AUIPC;
    if (i_jal)    dec_o.exc_op = id_pkg::EXC_JAL;
    if (i_jalr)   dec_o.exc_op = id_pkg::EXC_JALR;
    if (c_load)   dec_o.exc_op = id_pkg::EXC_LOAD;
    if (c_store)  dec_o.exc_op = id_pkg::EXC_STORE;
    if (c_branch) dec_o.exc_op = id_pkg::EXC_BRANCH;
    if (c_opimm)  dec_o.exc_op = id_pkg::EXC_OPIMM;
    if (c_opreg)  dec_o.exc_op = id_pkg::EXC_OPREG;
    if (c_system) dec_o.exc_op = id_pkg::EXC_SYSTEM;

    if (i_lb)  dec_o.mem_op = id_pkg::MEM_LB;
    if (i_lbu) dec_o.mem_op = id_pkg::MEM_LBU;
    if (i_lh)  dec_o.mem_op = id_pkg::MEM_LH;
    if (i_lhu) dec_o.mem_op = id_pkg::MEM_LHU;
    if (i_lw)  dec_o.mem_op = id_pkg::MEM_LW;
    if (i_sb)  dec_o.mem_op = id_pkg::MEM_SB;
    if (i_sh)  dec_o.mem_op = id_pkg::MEM_SH;
    if (i_sw)  dec_o.mem_op = id_pkg::MEM_SW;

    if (f_i) dec_o.imm_fmt = id_pkg::IMM_I;
    if (f_s) dec_o.imm_fmt = id_pkg::IMM_S;
    if (f_b) dec_o.imm_fmt = id_pkg::IMM_B;
    if (f_u) dec_o.imm_fmt = id_pkg::IMM_U;
    if (f_j) dec_o.imm_fmt = id_pkg::IMM_J;

    dec_o.trap.mret    = i_mret;
    dec_o.trap.ebreak  = i_ebreak;
    dec_o.trap.ecall_m = i_ecall;
    dec_o.trap.illegal = illegal;
    // rd of x0 is a plain jump, nothing to return to
    dec_o.is_call = (i_jal | i_jalr) & (inst_i[11:7] != 5'd0);
  end

endmodule

/* hw/decode/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
  input  id_pkg::word_t    inst_i,
  input  id_pkg::imm_fmt_e fmt_i,
  output id_pkg::word_t    imm_o
);

  always_comb begin
    case (fmt_i)
      id_pkg::IMM_I: imm_o = {{21{inst_i[31]}}, inst_i[30:20]};
      id_pkg::IMM_S: imm_o = {{21{inst_i[31]}}, inst_i[30:25], inst_i[11:7]};
      // branch offsets are halfword aligned
      id_pkg::IMM_B: imm_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25],
                              inst_i[11:8], 1'b0};
      id_pkg::IMM_U: imm_o = {inst_i[31:12], 12'd0};
      id_pkg::IMM_J: imm_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20],
                              inst_i[30:21], 1'b0};
      default:       imm_o = '0;
    endcase
  end

endmodule

/* hw/hazard/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass (
  input  id_pkg::reg_idx_t rs1_idx_i,
  input  id_pkg::reg_idx_t rs2_idx_i,
  input  id_pkg::word_t    rs1_data_i,
  input  id_pkg::word_t    rs2_data_i,
  input  logic             ex_valid_i,
  input  id_pkg::reg_idx_t ex_rd_idx_i,
  input  id_pkg::exc_op_e  ex_op_i,
  input  id_pkg::word_t    ex_rd_data_i,
  input  id_pkg::reg_idx_t mem_rd_addr_i,
  input  id_pkg::word_t    mem_rd_data_i,
  output id_pkg::word_t    rs1_o,
  output id_pkg::word_t    rs2_o,
  output logic             load_use_o
);

  // x0 never forwards
  function automatic logic src_hit(input id_pkg::reg_idx_t src, input id_pkg::reg_idx_t rd);
    src_hit = (src != 5'd0) && (src == rd);
  endfunction

  logic rs1_ex_hit;
  logic rs2_ex_hit;
  logic rs1_mem_hit;
  logic rs2_mem_hit;

  assign rs1_ex_hit  = ex_valid_i & src_hit(rs1_idx_i, ex_rd_idx_i);
  assign rs2_ex_hit  = ex_valid_i & src_hit(rs2_idx_i, ex_rd_idx_i);
  assign rs1_mem_hit = src_hit(rs1_idx_i, mem_rd_addr_i);
  assign rs2_mem_hit = src_hit(rs2_idx_i, mem_rd_addr_i);

  // newest result wins, write-back is already merged in the register file
  assign rs1_o = rs1_ex_hit  ? ex_rd_data_i  :
                 rs1_mem_hit ? mem_rd_data_i : rs1_data_i;
  assign rs2_o = rs2_ex_hit  ? ex_rd_data_i  :
                 rs2_mem_hit ? mem_rd_data_i : rs2_data_i;

  // load data is not ready until the memory stage
  assign load_use_o = (ex_op_i == id_pkg::EXC_LOAD) & (rs1_ex_hit | rs2_ex_hit);

endmodule

/* hw/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            in_valid_i,
  input  id_pkg::word_t   pc_i,
  input  id_pkg::word_t   inst_i,
  input  id_pkg::decode_t dec_i,
  input  id_pkg::word_t   imm_i,
  input  id_pkg::word_t   rs1_i,
  input  id_pkg::word_t   rs2_i,
  input  logic            load_use_i,
  input  logic            flush_i,
  output id_pkg::id_ex_t  ex_o,
  output logic            ras_push_valid_o,
  output id_pkg::word_t   ras_push_data_o
);

  logic             accept;
  logic             valid_q;
  id_pkg::reg_idx_t rd_q;
  id_pkg::alu_op_e  alu_q;
  id_pkg::exc_op_e  exc_q;
  id_pkg::mem_op_e  mem_q;
  id_pkg::trap_t    trap_q;
  id_pkg::word_t    pc_q;
  id_pkg::word_t    inst_q;
  id_pkg::word_t    rs1_q;
  id_pkg::word_t    rs2_q;
  id_pkg::word_t    imm_q;

  assign accept = in_valid_i & ~load_use_i & ~flush_i;

  // anything not accepted becomes a bubble
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q          <= 1'b0;
      rd_q             <= '0;
      alu_q            <= id_pkg::ALU_NONE;
      exc_q            <= id_pkg::EXC_NONE;
      mem_q            <= id_pkg::MEM_NONE;
      trap_q           <= '0;
      ras_push_valid_o <= 1'b0;
    end else begin
      valid_q          <= accept;
      rd_q             <= accept ? dec_i.rd_idx : 5'd0;
      alu_q            <= accept ? dec_i.alu_op : id_pkg::ALU_NONE;
      exc_q            <= accept ? dec_i.exc_op : id_pkg::EXC_NONE;
      mem_q            <= accept ? dec_i.mem_op : id_pkg::MEM_NONE;
      trap_q           <= accept ? dec_i.trap : '0;
      ras_push_valid_o <= accept & dec_i.is_call;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pc_q            <= pc_i;
      inst_q          <= inst_i;
      rs1_q           <= rs1_i;
      rs2_q           <= rs2_i;
      imm_q           <= imm_i;
      ras_push_data_o <= pc_i + id_pkg::CALL_RET_OFFSET;
    end
  end

  assign ex_o = '{valid: valid_q, pc: pc_q, inst: inst_q, rd_idx: rd_q,
                  rs1_data: rs1_q, rs2_data: rs2_q, imm: imm_q,
                  alu_op: alu_q, exc_op: exc_q, mem_op: mem_q, trap: trap_q};

endmodule

/* hw/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             in_valid_i,
  input  id_pkg::word_t    inst_i,
  input  id_pkg::word_t    pc_i,
  input  id_pkg::word_t    rs1_data_i,
  input  id_pkg::word_t    rs2_data_i,
  input  id_pkg::word_t    ex_rd_data_i,
  input  id_pkg::reg_idx_t mem_rd_addr_i,
  input  id_pkg::word_t    mem_rd_data_i,
  input  logic             flush_i,
  output id_pkg::reg_idx_t rs1_idx_o,
  output id_pkg::reg_idx_t rs2_idx_o,
  output logic             stall_o,
  output id_pkg::id_ex_t   ex_o,
  output logic             ras_push_valid_o,
  output id_pkg::word_t    ras_push_data_o
);

  id_pkg::decode_t dec;
  id_pkg::word_t   imm;
  id_pkg::word_t   rs1_fwd;
  id_pkg::word_t   rs2_fwd;

  assign rs1_idx_o = dec.rs1_idx;
  assign rs2_idx_o = dec.rs2_idx;

  inst_decoder u_dec (
    .inst_i (inst_i),
    .dec_o  (dec)
  );

  imm_gen u_imm (
    .inst_i (inst_i),
    .fmt_i  (dec.imm_fmt),
    .imm_o  (imm)
  );

  // execute-side view comes straight from the local ID/EX register
  operand_bypass u_byp (
    .rs1_idx_i     (dec.rs1_idx),
    .rs2_idx_i     (dec.rs2_idx),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .ex_valid_i    (ex_o.valid),
    .ex_rd_idx_i   (ex_o.rd_idx),
    .ex_op_i       (ex_o.exc_op),
    .ex_rd_data_i  (ex_rd_data_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .mem_rd_data_i (mem_rd_data_i),
    .rs1_o         (rs1_fwd),
    .rs2_o         (rs2_fwd),
    .load_use_o    (stall_o)
  );

  id_ex_reg u_reg (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .in_valid_i       (in_valid_i),
    .pc_i             (pc_i),
    .inst_i           (inst_i),
    .dec_i            (dec),
    .imm_i            (imm),
    .rs1_i            (rs1_fwd),
    .rs2_i            (rs2_fwd),
    .load_use_i       (stall_o),
    .flush_i          (flush_i),
    .ex_o             (ex_o),
    .ras_push_valid_o (ras_push_valid_o),
    .ras_push_data_o  (ras_push_data_o)
  );

endmodule

/* verification/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;

  localparam int NUM_CASES  = 20;
  localparam int NUM_COLS   = 21;
  localparam int MAX_CYCLES = 2 * NUM_CASES + 20;

  logic                    clk;
  logic                    arst_n;
  logic                    in_valid;
  id_pkg::word_t           inst;
  id_pkg::word_t           pc;
  id_pkg::word_t           rs1_data;
  id_pkg::word_t           rs2_data;
  id_pkg::word_t           ex_rd_data;
  id_pkg::reg_idx_t        mem_rd_addr;
  id_pkg::word_t           mem_rd_data;
  logic                    flush;
  id_pkg::reg_idx_t        rs1_idx;
  id_pkg::reg_idx_t        rs2_idx;
  logic                    stall;
  id_pkg::id_ex_t          ex;
  logic                    ras_push_valid;
  id_pkg::word_t           ras_push_data;

  logic [31:0] cases [0:NUM_CASES*NUM_COLS-1];
  int          cycles;

  id_stage uut (
    .clk              (clk),
    .arst_n_i         (arst_n),
    .in_valid_i       (in_valid),
    .inst_i           (inst),
    .pc_i             (pc),
    .rs1_data_i       (rs1_data),
    .rs2_data_i       (rs2_data),
    .ex_rd_data_i     (ex_rd_data),
    .mem_rd_addr_i    (mem_rd_addr),
    .mem_rd_data_i    (mem_rd_data),
    .flush_i          (flush),
    .rs1_idx_o        (rs1_idx),
    .rs2_idx_o        (rs2_idx),
    .stall_o          (stall),
    .ex_o             (ex),
    .ras_push_valid_o (ras_push_valid),
    .ras_push_data_o  (ras_push_data)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  // guard against a stuck run
  initial begin
    wait (cycles >= MAX_CYCLES);
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("FAIL: see errors above");
    $fatal(1);
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // formats R, I, S and B carry rs1
  function automatic logic reads_rs1(input logic [3:0] exc);
    reads_rs1 = exc == id_pkg::EXC_JALR || exc == id_pkg::EXC_LOAD ||
                exc == id_pkg::EXC_STORE || exc == id_pkg::EXC_BRANCH ||
                exc == id_pkg::EXC_OPIMM || exc == id_pkg::EXC_OPREG ||
                exc == id_pkg::EXC_SYSTEM;
  endfunction

  // formats R, S and B carry rs2
  function automatic logic reads_rs2(input logic [3:0] exc);
    reads_rs2 = exc == id_pkg::EXC_STORE || exc == id_pkg::EXC_BRANCH ||
                exc == id_pkg::EXC_OPREG;
  endfunction

  task automatic apply_case(input int idx);
    int base;
    base = idx * NUM_COLS;
    in_valid    = cases[base][0];
    flush       = cases[base+1][0];
    inst        = cases[base+2];
    pc          = cases[base+3];
    rs1_data    = cases[base+4];
    rs2_data    = cases[base+5];
    ex_rd_data  = cases[base+6];
    mem_rd_addr = cases[base+7][4:0];
    mem_rd_data = cases[base+8];
  endtask

  // the expected class of a captured row fixes which source fields exist
  task automatic verify_src_idx(input int idx);
    int          base;
    logic [3:0]  exc;
    logic [31:0] inst_w;
    base   = idx * NUM_COLS;
    exc    = cases[base+16][3:0];
    inst_w = cases[base+2];
    check_value("rs1_idx_o", 32'(rs1_idx), reads_rs1(exc) ? 32'(inst_w[19:15]) : 32'd0);
    check_value("rs2_idx_o", 32'(rs2_idx), reads_rs2(exc) ? 32'(inst_w[24:20]) : 32'd0);
  endtask

  // ex_o and the push after the edge that followed case idx
  task automatic check_capture(input int idx);
    int   base;
    logic exp_valid;
    logic exp_push;
    base      = idx * NUM_COLS;
    exp_valid = cases[base+10][0];
    exp_push  = cases[base+19][0];
    check_value("ex_o.valid", 32'(ex.valid), cases[base+10]);
    check_value("ex_o.rd_idx", 32'(ex.rd_idx), cases[base+11]);
    check_value("ex_o.alu_op", 32'(ex.alu_op), cases[base+15]);
    check_value("ex_o.exc_op", 32'(ex.exc_op), cases[base+16]);
    check_value("ex_o.mem_op", 32'(ex.mem_op), cases[base+17]);
    check_value("ex_o.trap", 32'(ex.trap), cases[base+18]);
    check_value("ras_push_valid_o", 32'(ras_push_valid), cases[base+19]);
    // data fields of a bubble are don't care
    if (exp_valid) begin
      check_value("ex_o.inst", ex.inst, cases[base+2]);
      check_value("ex_o.pc", ex.pc, cases[base+3]);
      check_value("ex_o.rs1_data", ex.rs1_data, cases[base+12]);
      check_value("ex_o.rs2_data", ex.rs2_data, cases[base+13]);
      check_value("ex_o.imm", ex.imm, cases[base+14]);
    end
    if (exp_push) begin
      check_value("ras_push_data_o", ras_push_data, cases[base+20]);
    end
  endtask

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    in_valid    = 1'b0;
    inst        = '0;
    pc          = '0;
    rs1_data    = '0;
    rs2_data    = '0;
    ex_rd_data  = '0;
    mem_rd_addr = '0;
    mem_rd_data = '0;
    flush       = 1'b0;
    $readmemh("verification/id_stage_cases.hex", cases);

    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_value("ex_o.valid", 32'(ex.valid), 32'd0);
    check_value("ras_push_valid_o", 32'(ras_push_valid), 32'd0);

    for (int i = 0; i < NUM_CASES; i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_capture(i - 1);
      end
      apply_case(i);
      // stall is combinational so sample it well before the rising edge
      #1;
      check_value("stall_o", 32'(stall), cases[i*NUM_COLS+9]);
      if (cases[i*NUM_COLS+10][0]) begin
        verify_src_idx(i);
      end
    end
    @(negedge clk);
    check_capture(NUM_CASES - 1);

    $display("PASS: all tests");
    $finish;
  end

endmodule

/* verification/id_stage_cases.hex */
// valid flush inst pc rs1_data rs2_data ex_rd_data mem_rd_addr mem_rd_data, then expected:
// stall ex_valid rd rs1 rs2 imm alu_op exc_op mem_op trap ras_valid ras_data
1 0 800002b7 100 11 22 e0 0 40  0 1 5 11 22 80000000 1 1 0 0 0 0
1 0 fffff317 104 11 22 e0 0 40  0 1 6 11 22 fffff000 1 2 0 0 0 0
1 0 800000ef 108 11 22 e0 0 40  0 1 1 11 22 fff00000 1 3 0 0 1 10c
1 0 fff18167 10c 11 22 e0 0 40  0 1 2 11 22 ffffffff 1 4 0 0 1 110
1 0 80839063 110 11 22 e0 0 40  0 1 0 11 22 fffff000 c 7 0 0 0 0
1 0 80952023 114 11 22 e0 0 40  0 1 0 11 22 fffff800 1 6 8 0 0 0
1 0 0046a603 118 11 22 e0 0 40  0 1 c 11 22 4 1 5 5 0 0 0
1 0 00f60733 11c 11 22 e0 0 40  1 0 0 0 0 0 0 0 0 0 0 0
1 0 00f60733 11c 11 22 e0 c 40  0 1 e 40 22 0 1 9 0 0 0 0
1 0 40070833 120 11 22 e0 e 40  0 1 10 e0 22 0 2 9 0 0 0 0
1 0 03498933 124 11 22 e0 13 40 0 1 12 40 22 0 11 9 0 0 0 0
1 0 403b5a93 128 11 22 e0 0 40  0 1 15 11 22 403 8 8 0 0 0 0
1 0 00000073 12c 11 22 e0 0 40  0 1 0 11 22 0 0 a 0 2 0 0
1 0 00100073 130 11 22 e0 0 40  0 1 0 11 22 1 0 a 0 4 0 0
1 0 30200073 134 11 22 e0 0 40  0 1 0 11 22 302 0 a 0 8 0 0
1 0 30011073 138 11 22 e0 0 40  0 1 0 11 22 0 0 0 0 1 0 0
1 0 ffffffff 13c 11 22 e0 0 40  0 1 0 11 22 0 0 0 0 1 0 0
1 0 0000006f 140 11 22 e0 0 40  0 1 0 11 22 0 1 3 0 0 0 0
1 1 000000ef 144 11 22 e0 0 40  0 0 0 0 0 0 0 0 0 0 0 0
0 0 ffffffff 148 11 22 e0 0 40  0 0 0 0 0 0 0 0 0 0 0 0

/* id_stage.f */
common/id_pkg.sv
hw/decode/inst_decoder.sv
hw/decode/imm_gen.sv
hw/hazard/operand_bypass.sv
hw/id_ex_reg.sv
hw/id_stage.sv
verification/tb_id_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the id_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f id_stage.f --top-module tb_id_stage -o sim_id_stage
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_id_stage > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0
